// File: source/rx_pcs_pkg.sv
package rx_pcs_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int BLOCK_W   = 64;
    localparam int HDR_W     = 2;
    localparam int COL_W     = 8;
    localparam int ERR_CNT_W = 8;

    ////////////////////
    // 64b/66b encoding
    ////////////////////

    // Sync headers
    localparam logic [HDR_W-1:0] HDR_DATA = 2'b01;
    localparam logic [HDR_W-1:0] HDR_CTRL = 2'b10;

    // Control block type bytes
    localparam logic [7:0] TYPE_IDLE  = 8'h1e;
    localparam logic [7:0] TYPE_START = 8'h78;

    // Terminate type bytes indexed by their count of data bytes
    localparam logic [7:0][7:0] TYPE_TERM = {
        8'hff,
        8'he1,
        8'hd2,
        8'hcc,
        8'hb4,
        8'haa,
        8'h99,
        8'h87
    };

    ////////////////////
    // XGMII characters
    ////////////////////

    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // Decoded block classification
    typedef enum logic [2:0] {
        KIND_DATA  = 3'd0,
        KIND_START = 3'd1,
        KIND_TERM  = 3'd2,
        KIND_IDLE  = 3'd3,
        KIND_BAD   = 3'd4
    } block_kind_t;

endpackage

// File: source/lane_decode.sv
`timescale 1ns/100ps

module lane_decode (
    input  logic                                rx_clk_161_13,
    input  logic                                async_reset_n,
    input  logic                                valid_i,
    input  logic [rx_pcs_pkg::HDR_W-1:0]        hdr_i,
    input  logic [rx_pcs_pkg::BLOCK_W-1:0]      data_i,
    output logic                                valid_o,
    output rx_pcs_pkg::block_kind_t             kind_o,
    output logic [rx_pcs_pkg::BLOCK_W-1:0]      rxd_o,
    output logic [rx_pcs_pkg::COL_W-1:0]        rxc_o
);

    logic [7:0]                         type_byte;
    logic [rx_pcs_pkg::BLOCK_W-1:0]     payload_sh;
    rx_pcs_pkg::block_kind_t            kind_d;
    logic [rx_pcs_pkg::BLOCK_W-1:0]     rxd_d;
    logic [rx_pcs_pkg::COL_W-1:0]       rxc_d;

    assign type_byte  = data_i[7:0];
    // Payload bytes 1..7 moved down to column bytes 0..6
    assign payload_sh = data_i >> 8;

    ////////////////////
    // Block decode
    ////////////////////

    always_comb begin
        kind_d = rx_pcs_pkg::KIND_BAD;
        rxd_d  = {8{rx_pcs_pkg::XGMII_ERROR}};
        rxc_d  = '1;

        if (hdr_i == rx_pcs_pkg::HDR_DATA) begin
            kind_d = rx_pcs_pkg::KIND_DATA;
            rxd_d  = data_i;
            rxc_d  = '0;
        end else if (hdr_i == rx_pcs_pkg::HDR_CTRL) begin
            if (type_byte == rx_pcs_pkg::TYPE_IDLE) begin
                kind_d = rx_pcs_pkg::KIND_IDLE;
                rxd_d  = {8{rx_pcs_pkg::XGMII_IDLE}};
                rxc_d  = '1;
            end else if (type_byte == rx_pcs_pkg::TYPE_START) begin
                kind_d = rx_pcs_pkg::KIND_START;
                rxd_d  = {data_i[63:8], rx_pcs_pkg::XGMII_START};
                rxc_d  = 8'h01;
            end else begin
                for (int k = 0; k < 8; k++) begin
                    if (type_byte == rx_pcs_pkg::TYPE_TERM[k]) begin
                        kind_d = rx_pcs_pkg::KIND_TERM;
                        for (int b = 0; b < 8; b++) begin
                            if (b < k) begin
                                rxd_d[8*b +: 8] = payload_sh[8*b +: 8];
                                rxc_d[b]        = 1'b0;
                            end else if (b == k) begin
                                rxd_d[8*b +: 8] = rx_pcs_pkg::XGMII_TERM;
                                rxc_d[b]        = 1'b1;
                            end else begin
                                rxd_d[8*b +: 8] = rx_pcs_pkg::XGMII_IDLE;
                                rxc_d[b]        = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Decoded kind and column
    always_ff @(posedge rx_clk_161_13) begin
        kind_o <= kind_d;
        rxd_o  <= rxd_d;
        rxc_o  <= rxc_d;
    end

endmodule

// File: source/packet_sequencer.sv
`timescale 1ns/100ps

module packet_sequencer #(
    parameter int NUM_LANES = 4
) (
    input  logic                                            rx_clk_161_13,
    input  logic                                            async_reset_n,
    input  logic                                            valid_i,
    input  rx_pcs_pkg::block_kind_t [NUM_LANES-1:0]         kind_i,
    input  logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]        rxd_i,
    input  logic [NUM_LANES*rx_pcs_pkg::COL_W-1:0]          rxc_i,
    output logic                                            valid_o,
    output logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]        rxd_o,
    output logic [NUM_LANES*rx_pcs_pkg::COL_W-1:0]          rxc_o,
    output logic [NUM_LANES-1:0]                            lane_err_o
);

    localparam int BW = rx_pcs_pkg::BLOCK_W;
    localparam int CW = rx_pcs_pkg::COL_W;

    // Framing state left behind by the last lane of the previous valid cycle
    logic                       in_pkt_q;
    logic                       in_pkt_d;
    logic                       in_pkt;
    logic                       legal;
    logic [NUM_LANES*BW-1:0]    rxd_d;
    logic [NUM_LANES*CW-1:0]    rxc_d;
    logic [NUM_LANES-1:0]       err_d;

    ////////////////////
    // Lane chain
    ////////////////////

    always_comb begin
        in_pkt = in_pkt_q;
        legal  = 1'b0;
        rxd_d  = rxd_i;
        rxc_d  = rxc_i;
        err_d  = '0;

        for (int n = 0; n < NUM_LANES; n++) begin
            case (kind_i[n])
                rx_pcs_pkg::KIND_DATA:  legal = in_pkt;
                rx_pcs_pkg::KIND_TERM:  legal = in_pkt;
                rx_pcs_pkg::KIND_IDLE:  legal = !in_pkt;
                rx_pcs_pkg::KIND_START: legal = !in_pkt;
                default:                legal = 1'b0;
            endcase

            if (!legal) begin
                rxd_d[n*BW +: BW] = {8{rx_pcs_pkg::XGMII_ERROR}};
                rxc_d[n*CW +: CW] = '1;
                err_d[n]          = 1'b1;
                in_pkt            = 1'b0;
            end else if (kind_i[n] == rx_pcs_pkg::KIND_START) begin
                in_pkt = 1'b1;
            end else if (kind_i[n] == rx_pcs_pkg::KIND_TERM) begin
                in_pkt = 1'b0;
            end
        end

        in_pkt_d = in_pkt;
    end

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            in_pkt_q <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // Idle cycles leave the framing untouched
            if (valid_i) begin
                in_pkt_q <= in_pkt_d;
            end
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        rxd_o      <= rxd_d;
        rxc_o      <= rxc_d;
        lane_err_o <= err_d;
    end

endmodule

// File: source/rx_result.sv
`timescale 1ns/100ps

module rx_result #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        rx_clk_161_13,
    input  logic                                        async_reset_n,
    input  logic                                        valid_i,
    input  logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]    rxd_i,
    input  logic [NUM_LANES*rx_pcs_pkg::COL_W-1:0]      rxc_i,
    input  logic [NUM_LANES-1:0]                        lane_err_i,
    input  logic                                        clear_errblk_i,
    output logic                                        xgmii_valid_o,
    output logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]    xgmii_rxd_o,
    output logic [NUM_LANES*rx_pcs_pkg::COL_W-1:0]      xgmii_rxc_o,
    output logic [rx_pcs_pkg::ERR_CNT_W-1:0]            errd_blks_o
);

    localparam int CNT_W = rx_pcs_pkg::ERR_CNT_W;

    logic [CNT_W:0]     err_inc;
    logic [CNT_W:0]     cnt_sum;
    logic [CNT_W-1:0]   cnt_d;

    ////////////////////
    // Errored blocks
    ////////////////////

    always_comb begin
        err_inc = '0;
        if (valid_i) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                err_inc = err_inc + {{CNT_W{1'b0}}, lane_err_i[n]};
            end
        end
        cnt_sum = {1'b0, errd_blks_o} + err_inc;
        // Carry out means the count passed its top
        cnt_d   = cnt_sum[CNT_W] ? {CNT_W{1'b1}} : cnt_sum[CNT_W-1:0];
    end

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            xgmii_valid_o <= 1'b0;
            errd_blks_o   <= '0;
        end else begin
            xgmii_valid_o <= valid_i;
            if (clear_errblk_i) begin
                errd_blks_o <= '0;
            end else begin
                errd_blks_o <= cnt_d;
            end
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        xgmii_rxd_o <= rxd_i;
        xgmii_rxc_o <= rxc_i;
    end

endmodule

// File: source/rx_pcs_top.sv
`timescale 1ns/100ps

module rx_pcs_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        rx_clk_161_13,
    input  logic                                        async_reset_n,
    input  logic                                        blk_valid_i,
    input  logic [NUM_LANES*rx_pcs_pkg::HDR_W-1:0]      lane_hdr_i,
    input  logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]    lane_data_i,
    input  logic                                        clear_errblk_i,
    output logic                                        xgmii_valid_o,
    output logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]    xgmii_rxd_o,
    output logic [NUM_LANES*rx_pcs_pkg::COL_W-1:0]      xgmii_rxc_o,
    output logic [rx_pcs_pkg::ERR_CNT_W-1:0]            errd_blks_o
);

    localparam int HW = rx_pcs_pkg::HDR_W;
    localparam int BW = rx_pcs_pkg::BLOCK_W;
    localparam int CW = rx_pcs_pkg::COL_W;

    // Decode stage outputs
    logic                                       dec_valid;
    rx_pcs_pkg::block_kind_t [NUM_LANES-1:0]    dec_kind;
    logic [NUM_LANES*BW-1:0]                    dec_rxd;
    logic [NUM_LANES*CW-1:0]                    dec_rxc;

    // Sequencer outputs
    logic                                       seq_valid;
    logic [NUM_LANES*BW-1:0]                    seq_rxd;
    logic [NUM_LANES*CW-1:0]                    seq_rxc;
    logic [NUM_LANES-1:0]                       seq_lane_err;

    ////////////////////
    // Per-lane decode
    ////////////////////

    // Lane 0 carries the strobe that all lanes share
    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        if (n == 0) begin : g_strobe
            lane_decode u_lane_decode (
                .rx_clk_161_13  (rx_clk_161_13),
                .async_reset_n  (async_reset_n),
                .valid_i        (blk_valid_i),
                .hdr_i          (lane_hdr_i[n*HW +: HW]),
                .data_i         (lane_data_i[n*BW +: BW]),
                .valid_o        (dec_valid),
                .kind_o         (dec_kind[n]),
                .rxd_o          (dec_rxd[n*BW +: BW]),
                .rxc_o          (dec_rxc[n*CW +: CW])
            );
        end else begin : g_plain
            lane_decode u_lane_decode (
                .rx_clk_161_13  (rx_clk_161_13),
                .async_reset_n  (async_reset_n),
                .valid_i        (blk_valid_i),
                .hdr_i          (lane_hdr_i[n*HW +: HW]),
                .data_i         (lane_data_i[n*BW +: BW]),
                .valid_o        (),
                .kind_o         (dec_kind[n]),
                .rxd_o          (dec_rxd[n*BW +: BW]),
                .rxc_o          (dec_rxc[n*CW +: CW])
            );
        end
    end

    packet_sequencer #(
        .NUM_LANES (NUM_LANES)
    ) u_packet_sequencer (
        .rx_clk_161_13  (rx_clk_161_13),
        .async_reset_n  (async_reset_n),
        .valid_i        (dec_valid),
        .kind_i         (dec_kind),
        .rxd_i          (dec_rxd),
        .rxc_i          (dec_rxc),
        .valid_o        (seq_valid),
        .rxd_o          (seq_rxd),
        .rxc_o          (seq_rxc),
        .lane_err_o     (seq_lane_err)
    );

    rx_result #(
        .NUM_LANES (NUM_LANES)
    ) u_rx_result (
        .rx_clk_161_13  (rx_clk_161_13),
        .async_reset_n  (async_reset_n),
        .valid_i        (seq_valid),
        .rxd_i          (seq_rxd),
        .rxc_i          (seq_rxc),
        .lane_err_i     (seq_lane_err),
        .clear_errblk_i (clear_errblk_i),
        .xgmii_valid_o  (xgmii_valid_o),
        .xgmii_rxd_o    (xgmii_rxd_o),
        .xgmii_rxc_o    (xgmii_rxc_o),
        .errd_blks_o    (errd_blks_o)
    );

endmodule

// File: dv/rx_pcs_model.svh
`ifndef RX_PCS_MODEL_SVH
`define RX_PCS_MODEL_SVH

localparam int CNT_MAX = (1 << rx_pcs_pkg::ERR_CNT_W) - 1;

// Framing flag after the last lane that was judged
logic                                       model_in_pkt = 1'b0;
logic [rx_pcs_pkg::ERR_CNT_W-1:0]           model_cnt = '0;
// Errored lanes of the two most recent driven cycles
logic                                       valid_d1 = 1'b0;
logic                                       valid_d2 = 1'b0;
int                                         errs_d1 = 0;
int                                         errs_d2 = 0;
logic [NUM_LANES*rx_pcs_pkg::BLOCK_W-1:0]   exp_rxd_q[$];
logic [NUM_LANES*rx_pcs_pkg::COL_W-1:0]     exp_rxc_q[$];
logic [rx_pcs_pkg::ERR_CNT_W-1:0]           exp_cnt_q[$];
time                                        exp_time_q[$];

function automatic void decode_block(input logic [1:0] hdr, input logic [63:0] data,
                                     output rx_pcs_pkg::block_kind_t kind,
                                     output logic [63:0] col_d, output logic [7:0] col_c);
    kind  = rx_pcs_pkg::KIND_BAD;
    col_d = '0;
    col_c = '1;
    if (hdr == rx_pcs_pkg::HDR_DATA) begin
        kind  = rx_pcs_pkg::KIND_DATA;
        col_d = data;
        col_c = '0;
    end else if (hdr == rx_pcs_pkg::HDR_CTRL) begin
        if (data[7:0] == rx_pcs_pkg::TYPE_IDLE) begin
            kind  = rx_pcs_pkg::KIND_IDLE;
            col_d = {8{rx_pcs_pkg::XGMII_IDLE}};
        end else if (data[7:0] == rx_pcs_pkg::TYPE_START) begin
            kind       = rx_pcs_pkg::KIND_START;
            col_d      = data;
            col_d[7:0] = rx_pcs_pkg::XGMII_START;
            col_c      = 8'h01;
        end
        for (int k = 0; k < 8; k++) begin
            if (data[7:0] == rx_pcs_pkg::TYPE_TERM[k]) begin
                kind = rx_pcs_pkg::KIND_TERM;
                for (int b = 0; b < 8; b++) begin
                    if (b < k) begin
                        col_d[8*b +: 8] = data[8*(b+1) +: 8];
                        col_c[b]        = 1'b0;
                    end else begin
                        col_d[8*b +: 8] = (b == k) ? rx_pcs_pkg::XGMII_TERM
                                                   : rx_pcs_pkg::XGMII_IDLE;
                    end
                end
            end
        end
    end
endfunction

function automatic void model_lane(input logic [1:0] hdr, input logic [63:0] data,
                                   output logic [63:0] col_d, output logic [7:0] col_c,
                                   output logic err);
    rx_pcs_pkg::block_kind_t kind;
    logic                    ok;
    decode_block(hdr, data, kind, col_d, col_c);
    case (kind)
        rx_pcs_pkg::KIND_DATA, rx_pcs_pkg::KIND_TERM:  ok = model_in_pkt;
        rx_pcs_pkg::KIND_IDLE, rx_pcs_pkg::KIND_START: ok = !model_in_pkt;
        default:                                       ok = 1'b0;
    endcase
    err = !ok;
    if (!ok) begin
        col_d        = {8{rx_pcs_pkg::XGMII_ERROR}};
        col_c        = '1;
        model_in_pkt = 1'b0;
    end else if (kind == rx_pcs_pkg::KIND_START) begin
        model_in_pkt = 1'b1;
    end else if (kind == rx_pcs_pkg::KIND_TERM) begin
        model_in_pkt = 1'b0;
    end
endfunction

// Clear driven now meets the result stage together with the cycle driven two edges ago
function automatic void model_count(input logic clear, input logic valid, input int errs);
    int sum;
    sum = int'(model_cnt) + errs_d2;
    if (clear) begin
        model_cnt = '0;
    end else begin
        model_cnt = (sum > CNT_MAX) ? '1 : sum[rx_pcs_pkg::ERR_CNT_W-1:0];
    end
    if (valid_d2) begin
        exp_cnt_q.push_back(model_cnt);
    end
    valid_d2 = valid_d1;
    errs_d2  = errs_d1;
    valid_d1 = valid;
    errs_d1  = valid ? errs : 0;
endfunction

`endif

// File: dv/rx_pcs_tb.sv
`timescale 1ns/100ps

module rx_pcs_tb;

    localparam int NUM_LANES    = 4;
    localparam int HW           = rx_pcs_pkg::HDR_W;
    localparam int BW           = rx_pcs_pkg::BLOCK_W;
    localparam int CW           = rx_pcs_pkg::COL_W;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES  = 3000;
    localparam int DRAIN_CYCLES = 8;
    localparam int MAX_CYCLES   = STIM_CYCLES + 50;
    // All lanes bad during the burst, so the counter must saturate
    localparam int BURST_START  = 2000;
    localparam int BURST_END    = 2200;
    localparam int LATENCY_NS   = 3 * CLK_PERIOD + CLK_PERIOD / 2;

    logic                               rx_clk_161_13;
    logic                               async_reset_n;
    logic                               blk_valid_i;
    logic [NUM_LANES*HW-1:0]            lane_hdr_i;
    logic [NUM_LANES*BW-1:0]            lane_data_i;
    logic                               clear_errblk_i;
    logic                               xgmii_valid_o;
    logic [NUM_LANES*BW-1:0]            xgmii_rxd_o;
    logic [NUM_LANES*CW-1:0]            xgmii_rxc_o;
    logic [rx_pcs_pkg::ERR_CNT_W-1:0]   errd_blks_o;

    logic [31:0]    lfsr_state = 32'hbf6fa7c9;
    int             cycle_cnt = 0;
    int             rd_idx = 0;
    logic           output_seen = 1'b0;
    logic           sat_seen = 1'b0;

    `include "rx_pcs_model.svh"

    rx_pcs_top #(
        .NUM_LANES (NUM_LANES)
    ) dut (
        .rx_clk_161_13  (rx_clk_161_13),
        .async_reset_n  (async_reset_n),
        .blk_valid_i    (blk_valid_i),
        .lane_hdr_i     (lane_hdr_i),
        .lane_data_i    (lane_data_i),
        .clear_errblk_i (clear_errblk_i),
        .xgmii_valid_o  (xgmii_valid_o),
        .xgmii_rxd_o    (xgmii_rxd_o),
        .xgmii_rxc_o    (xgmii_rxc_o),
        .errd_blks_o    (errd_blks_o)
    );

    always #(CLK_PERIOD / 2) rx_clk_161_13 = ~rx_clk_161_13;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic known_type(input logic [7:0] ty);
        logic hit;
        hit = (ty == rx_pcs_pkg::TYPE_IDLE) || (ty == rx_pcs_pkg::TYPE_START);
        for (int k = 0; k < 8; k++) begin
            hit = hit || (ty == rx_pcs_pkg::TYPE_TERM[k]);
        end
        return hit;
    endfunction

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s expected %0h actual %0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Fault 0 bad header, 1 unknown type, 2 out of order, 3 legal
    task automatic make_block(input logic burst, output logic [1:0] hdr,
                              output logic [63:0] data);
        logic [1:0] fault;
        logic       outside;
        logic [7:0] ty;
        data  = {rand_bits(32), rand_bits(32)};
        fault = 2'd3;
        if (burst) begin
            fault = 2'd0;
        end else if (rand_bits(4) == 32'd0) begin
            fault = 2'(rand_bits(2) % 32'd3);
        end
        if (fault == 2'd0) begin
            hdr = (rand_bits(1) != 32'd0) ? 2'b11 : 2'b00;
        end else if (fault == 2'd1) begin
            hdr = rx_pcs_pkg::HDR_CTRL;
            ty  = 8'(rand_bits(8));
            if (known_type(ty)) begin
                ty = 8'h2d;
            end
            data[7:0] = ty;
        end else begin
            outside = (model_in_pkt == (fault == 2'd2));
            if (outside) begin
                hdr       = rx_pcs_pkg::HDR_CTRL;
                data[7:0] = (rand_bits(1) != 32'd0) ? rx_pcs_pkg::TYPE_START
                                                    : rx_pcs_pkg::TYPE_IDLE;
            end else if (rand_bits(1) != 32'd0) begin
                hdr = rx_pcs_pkg::HDR_DATA;
            end else begin
                hdr       = rx_pcs_pkg::HDR_CTRL;
                data[7:0] = rx_pcs_pkg::TYPE_TERM[3'(rand_bits(3))];
            end
        end
    endtask

    task automatic drive_cycle(input int cyc, input logic active);
        logic                       burst;
        logic                       valid;
        logic                       clear;
        logic                       err;
        logic [1:0]                 hdr;
        logic [63:0]                data;
        logic [63:0]                col_d;
        logic [7:0]                 col_c;
        logic [NUM_LANES*HW-1:0]    hdr_vec;
        logic [NUM_LANES*BW-1:0]    data_vec;
        logic [NUM_LANES*BW-1:0]    exp_rxd;
        logic [NUM_LANES*CW-1:0]    exp_rxc;
        int                         errs;
        burst = active && (cyc >= BURST_START) && (cyc < BURST_END);
        valid = active && (burst || rand_bits(3) != 32'd0);
        clear = active && ((cyc == BURST_END) || (!burst && rand_bits(6) == 32'd0));
        errs  = 0;
        for (int n = 0; n < NUM_LANES; n++) begin
            make_block(burst, hdr, data);
            hdr_vec[n*HW +: HW]  = hdr;
            data_vec[n*BW +: BW] = data;
            if (valid) begin
                model_lane(hdr, data, col_d, col_c, err);
                exp_rxd[n*BW +: BW] = col_d;
                exp_rxc[n*CW +: CW] = col_c;
                errs += int'(err);
            end
        end
        if (valid) begin
            exp_rxd_q.push_back(exp_rxd);
            exp_rxc_q.push_back(exp_rxc);
            exp_time_q.push_back($time);
        end
        model_count(clear, valid, errs);
        blk_valid_i    <= valid;
        lane_hdr_i     <= hdr_vec;
        lane_data_i    <= data_vec;
        clear_errblk_i <= clear;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        rx_clk_161_13  = 1'b0;
        async_reset_n  = 1'b0;
        blk_valid_i    = 1'b0;
        lane_hdr_i     = '0;
        lane_data_i    = '0;
        clear_errblk_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge rx_clk_161_13);
        async_reset_n <= 1'b1;
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge rx_clk_161_13);
            drive_cycle(cyc, 1'b1);
        end
        repeat (DRAIN_CYCLES) begin
            @(posedge rx_clk_161_13);
            drive_cycle(0, 1'b0);
        end
        @(negedge rx_clk_161_13);
        if (rd_idx == exp_rxd_q.size() && sat_seen) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Run ended with %0d of %0d outputs seen, counter saturated %0b",
                     rd_idx, exp_rxd_q.size(), sat_seen);
            stop_on_failure();
        end
    end

    ////////////////////
    // Output checks
    ////////////////////

    always @(negedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            check_value("reset_valid", '0, 256'(xgmii_valid_o));
            check_value("reset_count", '0, 256'(errd_blks_o));
        end else if (xgmii_valid_o) begin
            if (rd_idx >= exp_rxd_q.size() || rd_idx >= exp_cnt_q.size()) begin
                $display("Output valid with no expected column left in the model");
                stop_on_failure();
            end else begin
                output_seen = 1'b1;
                check_value("xgmii_rxd", exp_rxd_q[rd_idx], xgmii_rxd_o);
                check_value("xgmii_rxc", 256'(exp_rxc_q[rd_idx]), 256'(xgmii_rxc_o));
                check_value("errd_blks", 256'(exp_cnt_q[rd_idx]), 256'(errd_blks_o));
                check_value("latency_ns", 256'(LATENCY_NS), 256'($time - exp_time_q[rd_idx]));
                if (int'(errd_blks_o) == CNT_MAX) begin
                    sat_seen = 1'b1;
                end
                rd_idx++;
            end
        end else if (!output_seen) begin
            check_value("count_before_output", '0, 256'(errd_blks_o));
        end
    end

    always @(posedge rx_clk_161_13) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles without reaching the end of the run", cycle_cnt);
            stop_on_failure();
        end
    end

endmodule

// File: files.f
+incdir+dv
source/rx_pcs_pkg.sv
source/lane_decode.sv
source/packet_sequencer.sv
source/rx_result.sv
source/rx_pcs_top.sv
dv/rx_pcs_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := rx_pcs_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
